//--- compile.f
src/VideoChipPkg.sv
src/SyncPkg.sv
src/RasterIf.sv
src/RasterCounter.sv
src/SerrationPulse.sv
src/EqualizationPulse.sv
src/SyncSequencer.sv
src/CompositeSync.sv
tb/ClockGen.sv
tb/SyncChecker.sv
tb/CompositeSyncTb.sv

//--- src/CompositeSync.sv
// ====================
// Composite sync generator
// Raster counter, serration and equalization decoders and the line sequencer
// ====================
`timescale 1ns/10ps

module CompositeSync #(
	parameter int rasterXWidth = VideoChipPkg::rasterXWidth,
	parameter int rasterYWidth = VideoChipPkg::rasterYWidth
) (
	input logic clk,
	input logic reset,
	input logic [1:0] chip,
	input logic turbo2,
	output logic csync,
	output logic [rasterXWidth-1:0] rasterX,
	output logic [rasterYWidth-1:0] rasterY
);
	import VideoChipPkg::*;

	logic serration;
	logic equalize;

	RasterIf #(.rasterXWidth(rasterXWidth), .rasterYWidth(rasterYWidth)) raster();

	// Mode levels are static and go straight onto the bundle
	assign raster.chip = chipType'(chip);
	assign raster.turbo2 = turbo2;

	// Beam position is also visible outside for the rest of the chip
	assign rasterX = raster.rasterX;
	assign rasterY = raster.rasterY;

	RasterCounter #(.rasterXWidth(rasterXWidth), .rasterYWidth(rasterYWidth)) counter (
		.clk(clk),
		.reset(reset),
		.raster(raster.counter)
	);

	SerrationPulse #(.rasterXWidth(rasterXWidth)) serrationDecoder (
		.raster(raster.decoder),
		.serration(serration)
	);

	EqualizationPulse #(.rasterXWidth(rasterXWidth)) equalizeDecoder (
		.raster(raster.decoder),
		.equalize(equalize)
	);

	SyncSequencer #(.rasterYWidth(rasterYWidth)) sequencer (
		.clk(clk),
		.reset(reset),
		.raster(raster.sequencer),
		.serration(serration),
		.equalize(equalize),
		.csync(csync)
	);

endmodule

//--- src/EqualizationPulse.sv
// ====================
// Equalization pulse decoder
// Two narrow low pulses per line, one at the line start and one at the half line
// ====================
`timescale 1ns/10ps

module EqualizationPulse #(
	parameter int rasterXWidth = VideoChipPkg::rasterXWidth
) (
	RasterIf.decoder raster,
	output logic equalize
);
	import VideoChipPkg::*;
	import SyncPkg::*;

	logic [rasterXWidth-1:0] pulseWidth;
	logic [rasterXWidth-1:0] midLine;
	logic [rasterXWidth-1:0] midPulseEnd;
	logic [rasterXWidth-1:0] notchEnd;

	assign pulseWidth = rasterXWidth'(equalizeWidth(raster.turbo2));
	assign midLine = rasterXWidth'(halfLine(raster.chip, raster.turbo2));
	assign midPulseEnd = midLine + pulseWidth;

	// Start of the second serration notch, used only by the check below
	assign notchEnd = rasterXWidth'(serrationEnd(raster.chip, raster.turbo2));

	// Low for pulseWidth dots after dot 0 and again after the half line
	assign equalize = !((raster.rasterX < pulseWidth) ||
		((raster.rasterX >= midLine) && (raster.rasterX < midPulseEnd)));

	// ==================== Checks

	// The second equalizing pulse has to end before the serration notch begins
	always_comb begin
		assert final (equalize || (raster.rasterX < notchEnd))
			else $error("equalizing pulse overlaps the serration notch");
	end

endmodule

//--- src/RasterCounter.sv
// ====================
// Raster counter
// Steps the dot position every clock and the line at each line wrap,
// using the totals of the chip that is selected
// ====================
`timescale 1ns/10ps

module RasterCounter #(
	parameter int rasterXWidth = VideoChipPkg::rasterXWidth,
	parameter int rasterYWidth = VideoChipPkg::rasterYWidth
) (
	input logic clk,
	input logic reset,
	RasterIf.counter raster
);
	import VideoChipPkg::*;

	// Totals for the current mode
	logic [rasterXWidth-1:0] lineLimit;
	logic [rasterYWidth-1:0] frameLimit;

	// Incremented positions
	logic [rasterXWidth-1:0] nextX;
	logic [rasterYWidth-1:0] nextY;

	logic lineEnd;
	logic frameEnd;
	logic lineOutside;

	assign lineLimit = rasterXWidth'(lineTotal(raster.chip, raster.turbo2));
	assign frameLimit = rasterYWidth'(frameLines(raster.chip));

	assign nextX = raster.rasterX + 1'b1;
	assign nextY = raster.rasterY + 1'b1;

	// Compare with "not below" so a shorter line after a mode change still wraps
	assign lineEnd = nextX >= lineLimit;
	assign frameEnd = nextY >= frameLimit;

	// A line number past the frame only shows up after a mode change
	assign lineOutside = raster.rasterY >= frameLimit;

	always_ff @(posedge clk) begin
		if (reset) begin
			raster.rasterX <= '0;
			raster.rasterY <= '0;
		end else if (lineEnd) begin
			raster.rasterX <= '0;
			raster.rasterY <= frameEnd ? '0 : nextY;
		end else begin
			raster.rasterX <= nextX;
			// Pull a stray line number back into the frame at once
			if (lineOutside)
				raster.rasterY <= '0;
		end
	end

	// ==================== Checks

	// Once the mode has held for a clock both counters sit inside the frame
	assert property (@(posedge clk) disable iff (reset)
		$stable(raster.chip) && $stable(raster.turbo2) |->
			(raster.rasterX < lineLimit) && (raster.rasterY < frameLimit))
		else $error("raster position outside the frame of the selected chip");

endmodule

//--- src/RasterIf.sv
// ====================
// Raster position bundle
// Carries the beam position and chip mode from the counter to the decoders
// ====================
`timescale 1ns/10ps

interface RasterIf #(
	parameter int rasterXWidth = VideoChipPkg::rasterXWidth,
	parameter int rasterYWidth = VideoChipPkg::rasterYWidth
);
	import VideoChipPkg::*;

	// Current dot within the line and current line within the frame
	logic [rasterXWidth-1:0] rasterX;
	logic [rasterYWidth-1:0] rasterY;

	// Static mode levels from outside the chip
	chipType chip;
	logic turbo2;

	// The counter owns the position and follows the mode
	modport counter (output rasterX, output rasterY, input chip, input turbo2);

	// Pulse decoders only look at the position and the mode
	modport decoder (input rasterX, input rasterY, input chip, input turbo2);

	// The sequencer also needs the line number to choose its phase
	modport sequencer (input rasterX, input rasterY, input chip, input turbo2);

endinterface

//--- src/SerrationPulse.sv
// ====================
// Serration pulse decoder
// Gives the serrated vertical sync level from the dot position,
// high through each half line and low in the notch that ends it
// ====================
`timescale 1ns/10ps

module SerrationPulse #(
	parameter int rasterXWidth = VideoChipPkg::rasterXWidth
) (
	RasterIf.decoder raster,
	output logic serration
);
	import VideoChipPkg::*;

	// Window edges for the chip and rate in use
	logic [rasterXWidth-1:0] notchStart;
	logic [rasterXWidth-1:0] midLine;
	logic [rasterXWidth-1:0] notchEnd;

	logic firstHalfHigh;
	logic secondHalfHigh;

	// Notch in the first half runs from about 43% of the line to the middle
	assign notchStart = rasterXWidth'(serrationStart(raster.chip, raster.turbo2));

	// Second half line begins at 50%
	assign midLine = rasterXWidth'(halfLine(raster.chip, raster.turbo2));

	// Notch in the second half runs from about 93% to the end of the line
	assign notchEnd = rasterXWidth'(serrationEnd(raster.chip, raster.turbo2));

	always_comb begin
		// High from the line start up to the first notch
		firstHalfHigh = raster.rasterX < notchStart;

		// High again from the middle up to the second notch
		secondHalfHigh = (raster.rasterX >= midLine) && (raster.rasterX < notchEnd);

		// Low only inside either notch, which is the broad vsync pulse
		serration = firstHalfHigh || secondHalfHigh;
	end

endmodule

//--- src/SyncPkg.sv
// ====================
// Sync phase definitions
// Phases of the vertical interval, their line numbers and pulse widths
// ====================
package SyncPkg;

	// Waveform used on a line, in the order the frame walks through them
	typedef enum logic [1:0] {
		phaseNormal,
		phasePreEqualize,
		phaseVsync,
		phasePostEqualize
	} syncPhase;

	// Every group of the vertical interval is three lines long
	localparam logic [8:0] groupLines = 9'd3;

	// First line of each group
	localparam logic [8:0] preEqualizeLine = 9'd0;
	localparam logic [8:0] vsyncLine = preEqualizeLine + groupLines;
	localparam logic [8:0] postEqualizeLine = vsyncLine + groupLines;
	localparam logic [8:0] normalLine = postEqualizeLine + groupLines;

	// Horizontal sync width in dots, wider at the turbo2 rate
	function automatic logic [9:0] hsyncWidth(logic turbo2);
		if (turbo2)
			return 10'd44;
		return 10'd38;
	endfunction

	// Equalizing pulses are half as wide as a horizontal sync
	function automatic logic [9:0] equalizeWidth(logic turbo2);
		if (turbo2)
			return 10'd22;
		return 10'd19;
	endfunction

endpackage

//--- src/SyncSequencer.sv
// ====================
// Sync sequencer
// Picks the sync waveform for each line of the frame and registers
// the chosen level onto composite sync
// ====================
`timescale 1ns/10ps

module SyncSequencer #(
	parameter int rasterYWidth = VideoChipPkg::rasterYWidth
) (
	input logic clk,
	input logic reset,
	RasterIf.sequencer raster,
	input logic serration,
	input logic equalize,
	output logic csync
);
	import VideoChipPkg::*;
	import SyncPkg::*;

	syncPhase phase;
	syncPhase nextPhase;

	logic lastDot;
	logic [rasterYWidth-1:0] lineAfter;
	logic [rasterYWidth-1:0] nextLine;
	logic [rasterYWidth-1:0] upcomingLine;
	logic hsyncLow;
	logic syncLevel;

	// The counter wraps rasterX on the edge that follows the last dot
	assign lastDot = (raster.rasterX + 1'b1) >= lineTotal(raster.chip, raster.turbo2);

	assign lineAfter = raster.rasterY + 1'b1;
	assign nextLine = (lineAfter >= frameLines(raster.chip)) ? '0 : lineAfter;

	// Line the counter shows on the next clock, so the phase moves together with rasterY
	assign upcomingLine = lastDot ? nextLine : raster.rasterY;

	// ==================== Phase FSM

	always_comb begin
		nextPhase = phase;
		unique case (phase)
			phaseNormal:
				if (upcomingLine == preEqualizeLine)
					nextPhase = phasePreEqualize;
			phasePreEqualize:
				if (upcomingLine == vsyncLine)
					nextPhase = phaseVsync;
			phaseVsync:
				if (upcomingLine == postEqualizeLine)
					nextPhase = phasePostEqualize;
			phasePostEqualize:
				if (upcomingLine == normalLine)
					nextPhase = phaseNormal;
		endcase
	end

	// Right after reset line 0 is reached one dot late, where both waveforms are low anyway
	always_ff @(posedge clk) begin
		if (reset)
			phase <= phaseNormal;
		else
			phase <= nextPhase;
	end

	// ==================== Sync output

	// Ordinary horizontal sync at the start of the line
	assign hsyncLow = raster.rasterX < hsyncWidth(raster.turbo2);

	always_comb begin
		unique case (phase)
			phaseNormal: syncLevel = !hsyncLow;
			phasePreEqualize, phasePostEqualize: syncLevel = equalize;
			phaseVsync: syncLevel = serration;
		endcase
	end

	// Composite sync is active low and idles high during reset
	always_ff @(posedge clk) begin
		if (reset)
			csync <= 1'b1;
		else
			csync <= syncLevel;
	end

	// The vertical interval is walked one phase at a time and never jumps a group
	assert property (@(posedge clk) disable iff (reset)
		(phase == $past(phase)) || (phase == syncPhase'($past(phase) + 2'd1)))
		else $error("sync phase skipped a step");

endmodule

//--- src/VideoChipPkg.sv
// ====================
// Video chip timing
// Chip variants and the horizontal and vertical timing of each one,
// with the doubled-rate turbo2 line shared by every variant
// ====================
package VideoChipPkg;

	// Widths of the dot and line counters
	localparam int rasterXWidth = 10;
	localparam int rasterYWidth = 9;

	// Supported chip variants, NTSC first and then the two PAL parts
	typedef enum logic [1:0] {
		chip6567R8,
		chip6567Old,
		chip6569,
		chip6572
	} chipType;

	// Dots in one full line
	// The 6572 runs on the 6569 horizontal timing
	function automatic logic [9:0] lineTotal(chipType chip, logic turbo2);
		if (turbo2)
			return 10'd608;
		case (chip)
			chip6567R8: return 10'd520;
			chip6567Old: return 10'd512;
			default: return 10'd504;
		endcase
	endfunction

	// The half line sits exactly at the middle of every line length
	function automatic logic [9:0] halfLine(chipType chip, logic turbo2);
		return lineTotal(chip, turbo2) >> 1;
	endfunction

	// First dot of the serration notch in the first half line, about 43% of the line
	function automatic logic [9:0] serrationStart(chipType chip, logic turbo2);
		if (turbo2)
			return 10'd261;
		case (chip)
			chip6567R8: return 10'd224;
			chip6567Old: return 10'd220;
			default: return 10'd217;
		endcase
	endfunction

	// First dot of the notch in the second half line, about 93% of the line
	function automatic logic [9:0] serrationEnd(chipType chip, logic turbo2);
		if (turbo2)
			return 10'd565;
		case (chip)
			chip6567R8: return 10'd484;
			chip6567Old: return 10'd476;
			default: return 10'd469;
		endcase
	endfunction

	// Lines in one non-interlaced frame
	function automatic logic [8:0] frameLines(chipType chip);
		case (chip)
			chip6567R8: return 9'd263;
			chip6567Old: return 9'd262;
			default: return 9'd312;
		endcase
	endfunction

endpackage

//--- tb/ClockGen.sv
// ====================
// Testbench clock and power-on reset
// 40 ns clock, reset held for the first 16 rising edges
// ====================
`timescale 1ns/10ps

module ClockGen #(
	parameter int halfPeriod = 20,
	parameter int resetCycles = 16
) (
	output logic clk,
	output logic reset
);

	// Free-running clock, first rising edge at one half period
	initial begin
		clk = 1'b0;
		forever #(halfPeriod) clk = ~clk;
	end

	// Reset drops on a rising edge just like the other testbench drives
	initial begin
		reset = 1'b1;
		repeat (resetCycles) @(posedge clk);
		reset <= 1'b0;
	end

endmodule

//--- tb/CompositeSyncTb.sv
// ====================
// Composite sync testbench
// Runs every chip mode from the stimulus file for whole frames
// and reports the error counts of the checker
// ====================
`timescale 1ns/10ps

module CompositeSyncTb;

	logic clk;
	logic bootReset;
	logic runReset;
	logic reset;
	logic [1:0] chip;
	logic turbo2;
	logic csync;
	logic [9:0] rasterX;
	logic [8:0] rasterY;
	logic [9:0] expLineTotal;
	logic [8:0] expFrameLines;

	int framesDone;
	int csyncErrors;
	int rasterErrors;
	int timingErrors;
	int setupErrors;
	longint watchdogNs;

	// Record fields: chip, turbo2, frames, line total, lines per frame
	logic [47:0] records [0:15];

	assign reset = bootReset || runReset;

	ClockGen clockGen (
		.clk(clk),
		.reset(bootReset)
	);

	CompositeSync uut (
		.clk(clk),
		.reset(reset),
		.chip(chip),
		.turbo2(turbo2),
		.csync(csync),
		.rasterX(rasterX),
		.rasterY(rasterY)
	);

	SyncChecker syncChecker (
		.clk(clk),
		.reset(reset),
		.chip(chip),
		.turbo2(turbo2),
		.csync(csync),
		.rasterX(rasterX),
		.rasterY(rasterY),
		.expLineTotal(expLineTotal),
		.expFrameLines(expFrameLines),
		.framesDone(framesDone),
		.csyncErrors(csyncErrors),
		.rasterErrors(rasterErrors),
		.timingErrors(timingErrors)
	);

	// ==================== Watchdog

	// Armed once the length of all runs is known
	initial begin
		watchdogNs = 0;
		wait (watchdogNs != 0);
		#(watchdogNs);
		$display("Timeout: the runs did not complete their frames within %0d ns", watchdogNs);
		$display(">>> FAIL");
		$finish;
	end

	// ==================== Stimulus

	initial begin
		int idx;
		int recordCount;
		int target;
		longint budgetCycles;
		chip = 2'd0;
		turbo2 = 1'b0;
		runReset = 1'b0;
		expLineTotal = 10'd0;
		expFrameLines = 9'd0;
		setupErrors = 0;
		for (idx = 0; idx < 16; idx++)
			records[idx] = '0;
		$readmemh("tb/syncStimulus.txt", records);

		// A record with zero frames closes the list
		recordCount = 0;
		budgetCycles = 0;
		while (recordCount < 16 && records[recordCount][39:32] != 8'd0) begin
			budgetCycles += records[recordCount][39:32] * records[recordCount][31:16] *
				records[recordCount][15:0];
			recordCount++;
		end
		if (recordCount == 0) begin
			$display("The stimulus file holds no runs");
			setupErrors++;
		end

		// Half again the length of every frame at 40 ns per dot
		watchdogNs = budgetCycles * 40 * 3 / 2;

		wait (bootReset === 1'b0);
		for (idx = 0; idx < recordCount; idx++) begin
			@(posedge clk);
			chip <= records[idx][45:44];
			turbo2 <= records[idx][40];
			expLineTotal <= records[idx][25:16];
			expFrameLines <= records[idx][8:0];
			runReset <= 1'b1;
			target = framesDone + records[idx][39:32];
			repeat (16) @(posedge clk);
			runReset <= 1'b0;
			// The run ends when the checker has seen its last frame wrap
			while (framesDone < target)
				@(posedge clk);
		end

		$display("Errors: csync %0d, raster %0d, timing %0d, setup %0d",
			csyncErrors, rasterErrors, timingErrors, setupErrors);
		if (csyncErrors + rasterErrors + timingErrors + setupErrors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

//--- tb/SyncChecker.sv
// ====================
// Composite sync checker
// Rebuilds the expected sync level from the line and dot rules,
// checks the raster steps, the line and frame lengths and counts the frames seen
// ====================
`timescale 1ns/10ps

module SyncChecker (
	input logic clk,
	input logic reset,
	input logic [1:0] chip,
	input logic turbo2,
	input logic csync,
	input logic [9:0] rasterX,
	input logic [8:0] rasterY,
	input logic [9:0] expLineTotal,
	input logic [8:0] expFrameLines,
	output int framesDone,
	output int csyncErrors,
	output int rasterErrors,
	output int timingErrors
);

	// Reset as the DUT saw it on the last rising edge
	logic edgeReset = 1'b1;

	// Set by the first rising edge, before it the DUT outputs are unknown
	logic clockSeen = 1'b0;

	// Position and mode of the previous cycle, which the registered csync belongs to
	logic [9:0] prevX;
	logic [8:0] prevY;
	logic [1:0] prevChip;
	logic prevTurbo2;
	int lineCount;

	initial begin
		framesDone = 0;
		csyncErrors = 0;
		rasterErrors = 0;
		timingErrors = 0;
		lineCount = 0;
	end

	// ==================== Timing tables

	// Dots per line, the PAL parts share one length
	function automatic int dotsPerLine(logic [1:0] chipCode, logic turbo);
		if (turbo)
			return 608;
		case (chipCode)
			2'd0: return 520;
			2'd1: return 512;
			default: return 504;
		endcase
	endfunction

	// First dot of the notch before the half line
	function automatic int firstNotch(logic [1:0] chipCode, logic turbo);
		if (turbo)
			return 261;
		case (chipCode)
			2'd0: return 224;
			2'd1: return 220;
			default: return 217;
		endcase
	endfunction

	// First dot of the notch before the line end
	function automatic int secondNotch(logic [1:0] chipCode, logic turbo);
		if (turbo)
			return 565;
		case (chipCode)
			2'd0: return 484;
			2'd1: return 476;
			default: return 469;
		endcase
	endfunction

	// Sync level for one dot, low is the active level
	function automatic logic expectedSync(int x, int y, logic [1:0] chipCode, logic turbo);
		int half;
		int syncDots;
		int eqDots;
		logic low;
		half = dotsPerLine(chipCode, turbo) / 2;
		syncDots = turbo ? 44 : 38;
		eqDots = turbo ? 22 : 19;
		if (y >= 9)
			low = x < syncDots;
		else if (y >= 3 && y < 6)
			low = (x >= firstNotch(chipCode, turbo) && x < half) ||
				(x >= secondNotch(chipCode, turbo));
		else
			low = (x < eqDots) || (x >= half && x < half + eqDots);
		return !low;
	endfunction

	task automatic reportMismatch(string name, logic [31:0] expected, logic [31:0] actual);
		$display("** Error at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
	endtask

	// ==================== Comparison

	task automatic compareCycle();
		if (edgeReset) begin
			// Idle values while reset is held and in the first counted cycle
			if (csync !== 1'b1) begin
				reportMismatch("csync", 1, csync);
				csyncErrors++;
			end
			if (rasterX !== 10'd0) begin
				reportMismatch("rasterX", 0, rasterX);
				rasterErrors++;
			end
			if (rasterY !== 9'd0) begin
				reportMismatch("rasterY", 0, rasterY);
				rasterErrors++;
			end
			lineCount = 1;
		end else begin
			if (csync !== expectedSync(prevX, prevY, prevChip, prevTurbo2)) begin
				reportMismatch("csync", expectedSync(prevX, prevY, prevChip, prevTurbo2), csync);
				csyncErrors++;
			end
			if (rasterX == 10'd0) begin
				// Line wrap, the previous dot was the last one of the line
				if (prevX + 1 != expLineTotal) begin
					reportMismatch("rasterX", expLineTotal - 1, prevX);
					timingErrors++;
				end
				if (rasterY == 9'd0) begin
					if (lineCount != expFrameLines) begin
						reportMismatch("lines per frame", expFrameLines, lineCount);
						timingErrors++;
					end
					lineCount = 1;
					framesDone++;
				end else begin
					// Next line of the same frame
					if (rasterY !== prevY + 1) begin
						reportMismatch("rasterY", prevY + 1, rasterY);
						rasterErrors++;
					end
					lineCount++;
				end
			end else begin
				// Within a line the dot steps by one and the line holds
				if (rasterX !== prevX + 1) begin
					reportMismatch("rasterX", prevX + 1, rasterX);
					rasterErrors++;
				end
				if (rasterY !== prevY) begin
					reportMismatch("rasterY", prevY, rasterY);
					rasterErrors++;
				end
			end
		end
		prevX = rasterX;
		prevY = rasterY;
		prevChip = chip;
		prevTurbo2 = turbo2;
	endtask

	always @(posedge clk) begin
		edgeReset <= reset;
		clockSeen <= 1'b1;
	end

	// Outputs settle after the rising edge, so they are read on the falling one
	always @(negedge clk)
		if (clockSeen)
			compareCycle();

endmodule

//--- tb/syncStimulus.txt
// Fields: chip(1) _ turbo2(1) _ frames(2) _ line total(4) _ lines per frame(4), all hex
// Chips: 0 = 6567R8, 1 = 6567 old, 2 = 6569, 3 = 6572; a zero frame count ends the list
// Normal rate
0_0_02_0208_0107 // 6567R8, 520 dots, 263 lines, two frames
1_0_01_0200_0106 // 6567 old, 512 dots, 262 lines
2_0_01_01F8_0138 // 6569, 504 dots, 312 lines
3_0_01_01F8_0138 // 6572, 504 dots, 312 lines
// Turbo2 rate
0_1_01_0260_0107 // 6567R8, 608 dots, 263 lines
1_1_01_0260_0106 // 6567 old, 608 dots, 262 lines
2_1_01_0260_0138 // 6569, 608 dots, 312 lines
3_1_01_0260_0138 // 6572, 608 dots, 312 lines
